// ==== verif/turboCtrl_input.txt ====
# W addr data strobes | R addr expected | P byte | C count random
# T cycles | D divisor | all values hex
R 0 0
R 1 0
R 2 0
R 3 0
R 4 0
R 5 0
W 0 ffffffff 1
R 0 77
W 0 ffffffff e
R 0 f77
W 0 00000a52 3
R 0 a52
W 1 12345678 1
R 1 78
W 1 12345678 6
R 1 45678
W 4 a1b2c3d4 5
R 4 b200d4
W 4 a1b2c3d4 a
R 4 a1b2c3d4
W 3 00020100 7
R 3 20100
W 9 ffffffff f
R 9 0
R 4 a1b2c3d4
D 3
R 2 3
P 11
P 22
P 33
T 14
C 3 0
D 0
P 40
P 41
P 42
P 43
P 44
P 45
T 6
C 4 1
T 4
C 2 0
P 50
P 51
P 52
P 53
T 4
P 60
P 61
P 62
P 63
P 64
P 65
P 66
P 67
P 68
T 2
R 0 10a52
W 0 00010000 4
R 0 a52
W 3 000f0e07 7
T 3
R 3 f0e07
W 3 00020100 7
C 4 0
T 4
C 4 0
T 4
C 4 0
D 5
P 70
P 71
T 16

// ==== verilog.f ====
+incdir+hdl
hdl/turboPkg.sv
hdl/turboRegs.sv
hdl/outputFifo.sv
hdl/outputPacer.sv
hdl/dacSelect.sv
hdl/turboCtrl.sv
verif/turboCtrl_assert.sv
verif/turboCtrlTb.sv

// ==== Makefile ====
TOP = turboCtrlTb

.PHONY: all run lint clean

all: run

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): verilog.f $(wildcard hdl/*.sv hdl/*.svh verif/*.sv)
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP)

lint:
	verilator --lint-only --timing --assert -Wall -f verilog.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// ==== verif/turboCtrlTb.sv ====
`timescale 1ns/1ps

`include "turboMap_cfg.svh"

module turboCtrlTb;

    localparam int CMD_BOUND = 40;    // Cycles any one command may take.

    logic        busClk = 1'b0;
    logic        rstN;
    logic        cs;
    logic        wr0;
    logic        wr1;
    logic        wr2;
    logic        wr3;
    logic [12:0] addr;
    logic [31:0] dataIn;
    logic [31:0] dataOut;
    logic        decValid;
    logic [7:0]  decData;
    logic        creditReturn;
    logic        outValid;
    logic [7:0]  outData;
    logic [7:0]  dac0;
    logic [7:0]  dac1;
    logic [7:0]  dac2;
    logic [2:0]  codeRate;
    logic [2:0]  codeLength;
    logic [3:0]  maxIterations;
    logic [15:0] inverseMeanMantissa;
    logic [2:0]  inverseMeanExponent;
    logic [15:0] outputEnClkDiv;
    logic [31:0] asmParms;

    int          fd;
    int          cmdTotal = 0;
    bit          countDone = 1'b0;
    int          cycle = 0;
    int          nextReady = 0;
    int          creditModel = `CREDIT_INIT;
    logic [15:0] divModel = '0;
    bit          overflowModel = 1'b0;
    logic [7:0]  lastSent = '0;
    logic [3:0]  selModel [3] = '{default: 4'd0};
    logic [3:0]  prevSel [3] = '{default: 4'd0};
    logic [7:0]  prevLast = '0;
    int          prevLevel = 0;
    int          prevCredits = `CREDIT_INIT;
    logic [7:0]  fifoModel [$];

    turboCtrl u_dut (.*);

    always #5 busClk = ~busClk;

    task automatic failRun();
        $display("Simulation failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Mismatch %s: expected %0h, actual %0h", name, expected, actual);
            failRun();
        end
    endtask

    // Source codes 0, 1, 2 as sampled one cycle back.
    function automatic logic [7:0] dacExpect(input logic [3:0] sel);
        case (sel)
            4'd0:    return prevLast;
            4'd1:    return 8'(prevLevel);
            4'd2:    return 8'(prevCredits);
            default: return 8'h00;
        endcase
    endfunction

    task automatic stepCycle(input bit pushReq, input logic [7:0] pushVal,
                             input bit creditReq);
        bit sendExp;
        @(negedge busClk);
        checkValue("dac0 output", 32'(dacExpect(prevSel[0])), 32'(dac0));
        checkValue("dac1 output", 32'(dacExpect(prevSel[1])), 32'(dac1));
        checkValue("dac2 output", 32'(dacExpect(prevSel[2])), 32'(dac2));
        prevSel = selModel;
        prevLast = lastSent;
        prevLevel = fifoModel.size();
        prevCredits = creditModel;
        sendExp = (fifoModel.size() > 0) && (creditModel > 0) && (cycle >= nextReady);
        checkValue("outValid", 32'(sendExp), 32'(outValid));
        if (sendExp) begin
            checkValue("outData order", 32'(fifoModel[0]), 32'(outData));
        end
        if (pushReq) begin
            if (fifoModel.size() == `FIFO_DEPTH) begin
                overflowModel = 1'b1;    // Full, byte dropped.
            end else begin
                fifoModel.push_back(pushVal);
            end
        end
        if (sendExp) begin
            lastSent = fifoModel.pop_front();
            nextReady = cycle + int'(divModel) + 1;
        end
        creditModel = creditModel + int'(creditReq) - int'(sendExp);
        decValid = pushReq;
        decData = pushVal;
        creditReturn = creditReq;
        cs = 1'b0;
        {wr3, wr2, wr1, wr0} = 4'b0000;
        cycle++;
    endtask

    task automatic writeReg(input logic [12:0] a, input logic [31:0] d,
                            input logic [3:0] strb);
        stepCycle(1'b0, 8'h00, 1'b0);
        cs = 1'b1;
        addr = a;
        dataIn = d;
        {wr3, wr2, wr1, wr0} = strb;
        if (a == `TURBO_OUTPUT_CLK_DIV) begin
            if (strb[0]) divModel[7:0] = d[7:0];
            if (strb[1]) divModel[15:8] = d[15:8];
        end
        if (a == `TURBO_DAC_SELECT) begin
            if (strb[0]) selModel[0] = d[3:0];
            if (strb[1]) selModel[1] = d[11:8];
            if (strb[2]) selModel[2] = d[19:16];
        end
        if (a == `TURBO_CONTROL && strb[2] && d[`TURBO_OVERFLOW_BIT]) begin
            overflowModel = 1'b0;    // Write one to clear.
        end
    endtask

    // Setting outputs against the readback layout of the same word.
    task automatic checkSettings(input logic [12:0] a, input logic [31:0] expected);
        case (a)
            `TURBO_CONTROL: begin
                checkValue("codeRate output", 32'(expected[2:0]), 32'(codeRate));
                checkValue("codeLength output", 32'(expected[6:4]), 32'(codeLength));
                checkValue("maxIterations output", 32'(expected[11:8]),
                           32'(maxIterations));
            end
            `TURBO_INVERSE_MEAN: begin
                checkValue("inverseMeanMantissa output", 32'(expected[15:0]),
                           32'(inverseMeanMantissa));
                checkValue("inverseMeanExponent output", 32'(expected[18:16]),
                           32'(inverseMeanExponent));
            end
            `TURBO_OUTPUT_CLK_DIV: begin
                checkValue("outputEnClkDiv output", 32'(expected[15:0]),
                           32'(outputEnClkDiv));
            end
            `TURBO_ASM_PARMS: begin
                checkValue("asmParms output", expected, asmParms);
            end
            default: ;
        endcase
    endtask

    task automatic readReg(input logic [12:0] a, input logic [31:0] expected);
        stepCycle(1'b0, 8'h00, 1'b0);
        cs = 1'b1;
        addr = a;
        #1;
        checkValue($sformatf("read of address %0h", a), expected, dataOut);
        if (a == `TURBO_CONTROL) begin
            checkValue("overflow flag", 32'(overflowModel),
                       32'(dataOut[`TURBO_OVERFLOW_BIT]));
        end
        checkSettings(a, expected);
        cs = 1'b0;
        #1;
        checkValue($sformatf("read of address %0h with cs low", a), 32'h0, dataOut);
    endtask

    task automatic idleCycles(input int n);
        repeat (n) begin
            stepCycle(1'b0, 8'h00, 1'b0);
        end
    endtask

    task automatic returnCredits(input int n, input bit randomGap);
        repeat (n) begin
            if (randomGap) begin
                idleCycles(int'($urandom_range(3, 0)));
            end
            stepCycle(1'b0, 8'h00, 1'b1);
        end
    endtask

    task automatic readCommand(output bit got, output logic [7:0] op,
                               output logic [31:0] a, output logic [31:0] b,
                               output logic [31:0] c);
        logic [7:0]       tok;
        logic [8*128-1:0] skip;
        int               n;
        got = 1'b0;
        op = '0;
        a = '0;
        b = '0;
        c = '0;
        tok = '0;
        n = $fscanf(fd, "%s", tok);
        while (n == 1 && tok == "#") begin
            n = $fgets(skip, fd);    // Rest of a comment line.
            n = $fscanf(fd, "%s", tok);
        end
        if (n == 1) begin
            got = 1'b1;
            op = tok;
            case (tok)
                "W":      n = $fscanf(fd, "%h %h %h", a, b, c) - 3;
                "R", "C": n = $fscanf(fd, "%h %h", a, b) - 2;
                default:  n = $fscanf(fd, "%h", a) - 1;
            endcase
            if (n != 0) begin
                $display("Malformed line in the input data file");
                failRun();
            end
        end
    endtask

    initial begin
        wait (countDone);
        #((cmdTotal * CMD_BOUND + 20) * 10);
        $display("Timeout: commands did not finish within %0d cycles",
                 cmdTotal * CMD_BOUND + 20);
        failRun();
    end

    initial begin
        bit          got;
        logic [7:0]  op;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        void'($urandom(8283));
        rstN = 1'b0;
        cs = 1'b0;
        {wr3, wr2, wr1, wr0} = 4'b0000;
        addr = '0;
        dataIn = '0;
        decValid = 1'b0;
        decData = '0;
        creditReturn = 1'b0;
        fd = $fopen("verif/turboCtrl_input.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the input data file");
            failRun();
        end
        readCommand(got, op, a, b, c);
        while (got) begin
            cmdTotal++;
            readCommand(got, op, a, b, c);
        end
        $fclose(fd);
        if (cmdTotal == 0) begin
            $display("The input data file holds no commands");
            failRun();
        end
        countDone = 1'b1;
        fd = $fopen("verif/turboCtrl_input.txt", "r");
        repeat (10) @(negedge busClk);
        rstN = 1'b1;
        readCommand(got, op, a, b, c);
        while (got) begin
            case (op)
                "W": writeReg(a[12:0], b, c[3:0]);
                "R": readReg(a[12:0], b);
                "P": stepCycle(1'b1, a[7:0], 1'b0);
                "C": returnCredits(int'(a), b[0]);
                "T": idleCycles(int'(a));
                "D": writeReg(`TURBO_OUTPUT_CLK_DIV, a, 4'b0011);
                default: begin
                    $display("Unknown command in the input data file");
                    failRun();
                end
            endcase
            readCommand(got, op, a, b, c);
        end
        $fclose(fd);
        idleCycles(4);
        $display("Simulation passed");
        $finish;
    end

endmodule

// ==== verif/turboCtrl_assert.sv ====
`timescale 1ns/1ps

`include "turboMap_cfg.svh"

module turboCtrlAssert (
    input logic                     busClk,
    input logic                     rstN,
    input logic                     outValid,
    input logic                     creditReturn,
    input logic [`CREDIT_W-1:0]     credits,
    input logic [`FIFO_LEVEL_W-1:0] level
);

    int poolCount;    // Credits seen from the downstream side.

    always_ff @(posedge busClk) begin
        if (!rstN) begin
            poolCount <= `CREDIT_INIT;
        end else begin
            poolCount <= poolCount + int'(creditReturn) - int'(outValid);
        end
    end

    creditBound: assert property (@(posedge busClk) disable iff (!rstN)
        credits <= `CREDIT_W'(`CREDIT_INIT))
        else $error("credit count above the initial pool");

    // A send always spends a credit.
    sendNeedsCredit: assert property (@(posedge busClk) disable iff (!rstN)
        outValid |-> (poolCount > 0))
        else $error("outValid raised with no credit left");

    levelBound: assert property (@(posedge busClk) disable iff (!rstN)
        level <= `FIFO_LEVEL_W'(`FIFO_DEPTH))
        else $error("FIFO level above its depth");

endmodule

bind turboCtrl turboCtrlAssert u_assert (
    .busClk       (busClk),
    .rstN         (rstN),
    .outValid     (outValid),
    .creditReturn (creditReturn),
    .credits      (credits),
    .level        (level)
);

// ==== hdl/turboCtrl.sv ====
`timescale 1ns/1ps

`include "turboMap_cfg.svh"

module turboCtrl (
    input  logic               busClk,
    input  logic               rstN,
    input  logic               cs,
    input  logic               wr0,
    input  logic               wr1,
    input  logic               wr2,
    input  logic               wr3,
    input  logic [12:0]        addr,
    input  logic [31:0]        dataIn,
    output logic [31:0]        dataOut,
    input  logic               decValid,
    input  logic [7:0]         decData,
    input  logic               creditReturn,
    output logic               outValid,
    output logic [7:0]         outData,
    output logic [7:0]         dac0,
    output logic [7:0]         dac1,
    output logic [7:0]         dac2,
    output turboPkg::codeRateT codeRate,
    output turboPkg::codeLenT  codeLength,
    output logic [3:0]         maxIterations,
    output logic [15:0]        inverseMeanMantissa,
    output logic [2:0]         inverseMeanExponent,
    output turboPkg::clkDivT   outputEnClkDiv,
    output logic [31:0]        asmParms
);

    import turboPkg::*;

    dacSelT                   dac0Select;
    dacSelT                   dac1Select;
    dacSelT                   dac2Select;
    logic                     overflow;
    logic                     pop;
    logic [7:0]               headData;
    logic                     notEmpty;
    logic [`FIFO_LEVEL_W-1:0] level;
    logic [`CREDIT_W-1:0]     credits;

    turboRegs u_regs (
        .busClk              (busClk),
        .rstN                (rstN),
        .cs                  (cs),
        .wr0                 (wr0),
        .wr1                 (wr1),
        .wr2                 (wr2),
        .wr3                 (wr3),
        .addr                (addr),
        .dataIn              (dataIn),
        .overflow            (overflow),
        .dataOut             (dataOut),
        .codeRate            (codeRate),
        .codeLength          (codeLength),
        .maxIterations       (maxIterations),
        .inverseMeanMantissa (inverseMeanMantissa),
        .inverseMeanExponent (inverseMeanExponent),
        .outputEnClkDiv      (outputEnClkDiv),
        .dac0Select          (dac0Select),
        .dac1Select          (dac1Select),
        .dac2Select          (dac2Select),
        .asmParms            (asmParms)
    );

    outputFifo u_fifo (
        .busClk    (busClk),
        .rstN      (rstN),
        .pushValid (decValid),
        .pushData  (decData),
        .pop       (pop),
        .headData  (headData),
        .notEmpty  (notEmpty),
        .level     (level),
        .overflow  (overflow)
    );

    outputPacer u_pacer (
        .busClk         (busClk),
        .rstN           (rstN),
        .outputEnClkDiv (outputEnClkDiv),
        .notEmpty       (notEmpty),
        .headData       (headData),
        .creditReturn   (creditReturn),
        .pop            (pop),
        .outValid       (outValid),
        .outData        (outData),
        .credits        (credits)
    );

    dacSelect u_dac (
        .busClk     (busClk),
        .rstN       (rstN),
        .dac0Select (dac0Select),
        .dac1Select (dac1Select),
        .dac2Select (dac2Select),
        .lastValid  (outValid),
        .lastOut    (outData),
        .level      (level),
        .credits    (credits),
        .dac0       (dac0),
        .dac1       (dac1),
        .dac2       (dac2)
    );

endmodule

// ==== hdl/dacSelect.sv ====
`timescale 1ns/1ps

`include "turboMap_cfg.svh"

module dacSelect (
    input  logic                     busClk,
    input  logic                     rstN,
    input  turboPkg::dacSelT         dac0Select,
    input  turboPkg::dacSelT         dac1Select,
    input  turboPkg::dacSelT         dac2Select,
    input  logic                     lastValid,
    input  logic [7:0]               lastOut,
    input  logic [`FIFO_LEVEL_W-1:0] level,
    input  logic [`CREDIT_W-1:0]     credits,
    output logic [7:0]               dac0,
    output logic [7:0]               dac1,
    output logic [7:0]               dac2
);

    import turboPkg::*;

    logic [7:0] lastByte;

    function automatic logic [7:0] pickSource(dacSelT sel);
        logic [7:0] value;
        case (sel)
            DAC_SRC_LAST_OUT: value = lastByte;
            DAC_SRC_LEVEL:    value = 8'(level);
            DAC_SRC_CREDITS:  value = 8'(credits);
            default:          value = 8'h00;
        endcase
        return value;
    endfunction

    always_ff @(posedge busClk) begin
        if (!rstN) begin
            lastByte <= '0;
            dac0     <= '0;
            dac1     <= '0;
            dac2     <= '0;
        end else begin
            if (lastValid) begin
                lastByte <= lastOut;    // Byte taken downstream.
            end
            dac0 <= pickSource(dac0Select);
            dac1 <= pickSource(dac1Select);
            dac2 <= pickSource(dac2Select);
        end
    end

endmodule

// ==== hdl/outputPacer.sv ====
`timescale 1ns/1ps

`include "turboMap_cfg.svh"

module outputPacer (
    input  logic                 busClk,
    input  logic                 rstN,
    input  turboPkg::clkDivT     outputEnClkDiv,
    input  logic                 notEmpty,
    input  logic [7:0]           headData,
    input  logic                 creditReturn,
    output logic                 pop,
    output logic                 outValid,
    output logic [7:0]           outData,
    output logic [`CREDIT_W-1:0] credits
);

    import turboPkg::*;

    clkDivT divCnt;
    logic   divReady;
    logic   haveCredit;
    logic   send;

    assign divReady   = (divCnt == '0);
    assign haveCredit = (credits != '0);
    assign send       = notEmpty && haveCredit && divReady;

    assign pop      = send;       // Head leaves on the send edge.
    assign outValid = send;
    assign outData  = headData;

    // Reload on send, count down to zero.
    always_ff @(posedge busClk) begin
        if (!rstN) begin
            divCnt <= '0;
        end else if (send) begin
            divCnt <= outputEnClkDiv;
        end else if (!divReady) begin
            divCnt <= divCnt - 1'b1;
        end
    end

    always_ff @(posedge busClk) begin
        if (!rstN) begin
            credits <= `CREDIT_W'(`CREDIT_INIT);
        end else begin
            case ({send, creditReturn})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;    // Both or neither.
            endcase
        end
    end

endmodule

// ==== hdl/outputFifo.sv ====
`timescale 1ns/1ps

`include "turboMap_cfg.svh"

module outputFifo (
    input  logic                     busClk,
    input  logic                     rstN,
    input  logic                     pushValid,
    input  logic [7:0]               pushData,
    input  logic                     pop,
    output logic [7:0]               headData,
    output logic                     notEmpty,
    output logic [`FIFO_LEVEL_W-1:0] level,
    output logic                     overflow
);

    logic [7:0]             mem [0:`FIFO_DEPTH-1];
    logic [`FIFO_PTR_W-1:0] wrPtr;
    logic [`FIFO_PTR_W-1:0] rdPtr;
    logic                   full;
    logic                   doPush;
    logic                   doPop;

    assign full     = (level == `FIFO_LEVEL_W'(`FIFO_DEPTH));
    assign notEmpty = (level != '0);
    assign doPush   = pushValid && !full;
    assign doPop    = pop && notEmpty;
    assign overflow = pushValid && full;    // Byte dropped this cycle.
    assign headData = mem[rdPtr];

    always_ff @(posedge busClk) begin
        if (doPush) begin
            mem[wrPtr] <= pushData;
        end
    end

    always_ff @(posedge busClk) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            level <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= wrPtr + 1'b1;    // Wraps at depth.
            end
            if (doPop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({doPush, doPop})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;
            endcase
        end
    end

endmodule

// ==== hdl/turboRegs.sv ====
`timescale 1ns/1ps

`include "turboMap_cfg.svh"

module turboRegs (
    input  logic              busClk,
    input  logic              rstN,
    input  logic              cs,
    input  logic              wr0,
    input  logic              wr1,
    input  logic              wr2,
    input  logic              wr3,
    input  logic [12:0]       addr,
    input  logic [31:0]       dataIn,
    input  logic              overflow,
    output logic [31:0]       dataOut,
    output turboPkg::codeRateT codeRate,
    output turboPkg::codeLenT codeLength,
    output logic [3:0]        maxIterations,
    output logic [15:0]       inverseMeanMantissa,
    output logic [2:0]        inverseMeanExponent,
    output turboPkg::clkDivT  outputEnClkDiv,
    output turboPkg::dacSelT  dac0Select,
    output turboPkg::dacSelT  dac1Select,
    output turboPkg::dacSelT  dac2Select,
    output logic [31:0]       asmParms
);

    logic overflowFlag;
    logic overflowClear;

    assign overflowClear = cs && wr2 && (addr == `TURBO_CONTROL) &&
                           dataIn[`TURBO_OVERFLOW_BIT];

    // Byte lane 0.
    always_ff @(posedge busClk) begin
        if (!rstN) begin
            codeRate                 <= '0;
            codeLength               <= '0;
            inverseMeanMantissa[7:0] <= '0;
            outputEnClkDiv[7:0]      <= '0;
            dac0Select               <= '0;
            asmParms[7:0]            <= '0;
        end else if (cs && wr0) begin
            case (addr)
                `TURBO_CONTROL: begin
                    codeRate   <= dataIn[2:0];
                    codeLength <= dataIn[6:4];
                end
                `TURBO_INVERSE_MEAN:   inverseMeanMantissa[7:0] <= dataIn[7:0];
                `TURBO_OUTPUT_CLK_DIV: outputEnClkDiv[7:0]      <= dataIn[7:0];
                `TURBO_DAC_SELECT:     dac0Select               <= dataIn[3:0];
                `TURBO_ASM_PARMS:      asmParms[7:0]            <= dataIn[7:0];
                default: ;
            endcase
        end
    end

    // Byte lane 1.
    always_ff @(posedge busClk) begin
        if (!rstN) begin
            maxIterations             <= '0;
            inverseMeanMantissa[15:8] <= '0;
            outputEnClkDiv[15:8]      <= '0;
            dac1Select                <= '0;
            asmParms[15:8]            <= '0;
        end else if (cs && wr1) begin
            case (addr)
                `TURBO_CONTROL:        maxIterations             <= dataIn[11:8];
                `TURBO_INVERSE_MEAN:   inverseMeanMantissa[15:8] <= dataIn[15:8];
                `TURBO_OUTPUT_CLK_DIV: outputEnClkDiv[15:8]      <= dataIn[15:8];
                `TURBO_DAC_SELECT:     dac1Select                <= dataIn[11:8];
                `TURBO_ASM_PARMS:      asmParms[15:8]            <= dataIn[15:8];
                default: ;
            endcase
        end
    end

    // Byte lane 2.
    always_ff @(posedge busClk) begin
        if (!rstN) begin
            inverseMeanExponent <= '0;
            dac2Select          <= '0;
            asmParms[23:16]     <= '0;
        end else if (cs && wr2) begin
            case (addr)
                `TURBO_INVERSE_MEAN: inverseMeanExponent <= dataIn[18:16];
                `TURBO_DAC_SELECT:   dac2Select          <= dataIn[19:16];
                `TURBO_ASM_PARMS:    asmParms[23:16]     <= dataIn[23:16];
                default: ;
            endcase
        end
    end

    // Byte lane 3.
    always_ff @(posedge busClk) begin
        if (!rstN) begin
            asmParms[31:24] <= '0;
        end else if (cs && wr3 && (addr == `TURBO_ASM_PARMS)) begin
            asmParms[31:24] <= dataIn[31:24];
        end
    end

    // Sticky overflow, set beats clear.
    always_ff @(posedge busClk) begin
        if (!rstN) begin
            overflowFlag <= 1'b0;
        end else if (overflow) begin
            overflowFlag <= 1'b1;
        end else if (overflowClear) begin
            overflowFlag <= 1'b0;
        end
    end

    always_comb begin
        dataOut = '0;
        if (cs) begin
            case (addr)
                `TURBO_CONTROL:        dataOut = {15'b0, overflowFlag,
                                                  4'b0, maxIterations,
                                                  1'b0, codeLength, 1'b0, codeRate};
                `TURBO_INVERSE_MEAN:   dataOut = {13'b0, inverseMeanExponent,
                                                  inverseMeanMantissa};
                `TURBO_OUTPUT_CLK_DIV: dataOut = {16'b0, outputEnClkDiv};
                `TURBO_DAC_SELECT:     dataOut = {8'b0,
                                                  4'b0, dac2Select,
                                                  4'b0, dac1Select,
                                                  4'b0, dac0Select};
                `TURBO_ASM_PARMS:      dataOut = asmParms;
                default:               dataOut = '0;    // Unmapped.
            endcase
        end
    end

endmodule

// ==== hdl/turboPkg.sv ====
package turboPkg;

    // Decoder setting fields.
    typedef logic [2:0] codeRateT;
    typedef logic [2:0] codeLenT;

    // Output pacing divisor, in bus clocks.
    typedef logic [15:0] clkDivT;

    // DAC source select code.
    typedef logic [3:0] dacSelT;

    // Debug sources routed to the DACs.
    localparam dacSelT DAC_SRC_LAST_OUT = 4'd0;    // Last byte sent.
    localparam dacSelT DAC_SRC_LEVEL    = 4'd1;    // FIFO fill level.
    localparam dacSelT DAC_SRC_CREDITS  = 4'd2;    // Credit count.

endpackage

// ==== hdl/turboMap_cfg.svh ====
`ifndef TURBO_MAP_CFG_SVH
`define TURBO_MAP_CFG_SVH

// Host register map, 13-bit word addresses.
`define TURBO_CONTROL        13'd0
`define TURBO_INVERSE_MEAN   13'd1
`define TURBO_OUTPUT_CLK_DIV 13'd2
`define TURBO_DAC_SELECT     13'd3
`define TURBO_ASM_PARMS      13'd4

// Overflow flag position in the control register.
`define TURBO_OVERFLOW_BIT   16

// Output FIFO geometry.
`define FIFO_DEPTH           8
`define FIFO_PTR_W           3    // Log2 of depth.
`define FIFO_LEVEL_W         4    // Holds 0 to depth.

// Downstream credit pool.
`define CREDIT_INIT          4
`define CREDIT_W             3    // Holds 0 to CREDIT_INIT.

`endif
